// ==== list.f ====
hdl/console_pkg.sv
hdl/line_pkg.sv
hdl/console_ifs.sv
hdl/console_decoder.sv
hdl/line_buffer.sv
hdl/line_drain.sv
hdl/console_top.sv
sim/tb_clk_gen.sv
sim/tb_console.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     := --timing --assert
TOP       := tb_console
FILELIST  := list.f
BUILD_DIR := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== sim/tb_console.sv ====
`timescale 1ns/1ps

module tb_console
  import console_pkg::*;
  import line_pkg::*;
();

  // Roughly 230 writes plus drain time, far below this
  localparam int          TIMEOUT_CYCLES = 4000;
  localparam logic [31:0] LFSR_TAPS      = 32'h80200003;

  logic               clk;
  logic               arst_n;
  logic               wr_valid;
  addr_t              wr_addr;
  char_t              wr_data;
  logic               char_valid;
  char_t              char_data;
  tile_idx_t          char_tile;
  logic               err_valid;
  char_t              err_count;
  logic [N_TILES-1:0] overflow;

  char_t              exp_q [N_TILES][$];  // Expected beats per tile
  int                 line_len [N_TILES];  // Stored chars of the open line
  logic [N_TILES-1:0] exp_overflow;
  logic [31:0]        lfsr_state;
  string              test_name;
  int                 cycle_cnt = 0;
  logic               hold_active;         // hold_tile must stay silent
  tile_idx_t          hold_tile;
  logic               in_line;             // Between first char and newline
  tile_idx_t          line_tile;

  tb_clk_gen u_clk_gen (
    .clk      (clk),
    .arst_n_o (arst_n)
  );

  console_top dut_i (
    .clk          (clk),
    .arst_n_i     (arst_n),
    .wr_valid_i   (wr_valid),
    .wr_addr_i    (wr_addr),
    .wr_data_i    (wr_data),
    .char_valid_o (char_valid),
    .char_o       (char_data),
    .char_tile_o  (char_tile),
    .err_valid_o  (err_valid),
    .err_count_o  (err_count),
    .overflow_o   (overflow)
  );

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (exp == act)
      else stop_on_error($sformatf("Mismatch %s %s: expected %0h, actual %0h",
                                   test_name, what, exp, act));
  endtask

  function automatic logic [31:0] galois_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  // One step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v          = {v[30:0], lfsr_state[0]};
      lfsr_state = galois_next(lfsr_state);
    end
    return v;
  endfunction

  // Printable, never a newline
  function automatic char_t rand_char();
    return char_t'(32'h21 + (take_bits(8) % 32'd94));
  endfunction

  function automatic int pending();
    int n;
    n = 0;
    for (int t = 0; t < N_TILES; t++) n += exp_q[t].size();
    return n;
  endfunction

  task automatic bus_write(input addr_t addr, input char_t data);
    @(posedge clk);
    wr_valid <= 1'b1;
    wr_addr  <= addr;
    wr_data  <= data;
  endtask

  task automatic bus_idle(input int n);
    repeat (n) begin
      @(posedge clk);
      wr_valid <= 1'b0;
    end
  endtask

  // Model assumes the FIFO holds only the open line
  task automatic tile_put(input tile_idx_t t, input char_t c);
    if (c == NEWLINE_CHAR) begin
      exp_q[t].push_back(c);  // Always finds room
      line_len[t] = 0;
    end else if (line_len[t] < int'(LINE_DEPTH) - 1) begin
      exp_q[t].push_back(c);
      line_len[t]++;
    end else begin
      exp_overflow[t] = 1'b1;  // Dropped
    end
    bus_write(STDIO_BASE + addr_t'(t) * addr_t'(STDIO_STRIDE), c);
  endtask

  task automatic wait_drained();
    do @(negedge clk); while (pending() != 0);
  endtask

  // Outputs sampled mid-cycle
  always @(negedge clk) begin : monitor
    char_t exp_c;
    if (!arst_n) begin
      in_line = 1'b0;
    end else if (char_valid) begin
      assert (!(hold_active && char_tile == hold_tile))
        else stop_on_error($sformatf("Tile %0d sent output before its newline", hold_tile));
      assert (exp_q[char_tile].size() != 0)
        else stop_on_error($sformatf("Unexpected character %02h from tile %0d",
                                     char_data, char_tile));
      exp_c = exp_q[char_tile].pop_front();
      check_eq("char", 32'(exp_c), 32'(char_data));
      if (in_line) check_eq("line tile", 32'(line_tile), 32'(char_tile));  // No mixing
      in_line   = (char_data != NEWLINE_CHAR);
      line_tile = char_tile;
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) stop_on_error("Timeout, expected output never arrived");
  end

  initial begin : stimulus
    tile_idx_t          t;
    char_t              c;
    int                 len;
    logic [N_TILES-1:0] ovf_before;
    logic               err_v_before;
    wr_valid     <= 1'b0;
    wr_addr      <= '0;
    wr_data      <= '0;
    lfsr_state   = 32'h72e54e2a;
    exp_overflow = '0;
    hold_active  = 1'b0;
    hold_tile    = '0;
    for (int i = 0; i < N_TILES; i++) line_len[i] = 0;
    test_name = "reset";
    @(posedge arst_n);
    @(negedge clk);
    check_eq("err_valid", 32'(1'b0), 32'(err_valid));
    check_eq("overflow", 32'(exp_overflow), 32'(overflow));

    test_name = "single_line";
    t   = tile_idx_t'(take_bits(2));
    len = 1 + int'(take_bits(3));
    for (int i = 0; i < len; i++) tile_put(t, rand_char());
    tile_put(t, NEWLINE_CHAR);
    bus_idle(1);
    wait_drained();

    test_name   = "held_line";
    hold_tile   = tile_idx_t'(2);
    hold_active = 1'b1;
    for (int i = 0; i < 6; i++) tile_put(hold_tile, rand_char());
    bus_idle(30);  // Partial line just sits
    hold_active = 1'b0;
    tile_put(hold_tile, NEWLINE_CHAR);
    bus_idle(1);
    wait_drained();

    test_name = "interleaved";
    for (int i = 0; i < 160; i++) begin
      t = tile_idx_t'(take_bits(2));
      if (line_len[t] >= 4 || (line_len[t] > 0 && take_bits(2) == 0)) c = NEWLINE_CHAR;
      else c = rand_char();
      tile_put(t, c);
      bus_idle(int'(take_bits(2)));  // 0 to 3 gap cycles
    end
    for (int i = 0; i < N_TILES; i++) begin
      if (line_len[i] > 0) tile_put(tile_idx_t'(i), NEWLINE_CHAR);  // Close open lines
    end
    bus_idle(1);
    wait_drained();
    check_eq("overflow", 32'(exp_overflow), 32'(overflow));

    // All flags still clear here, so any stray set shows up
    test_name    = "unmapped";
    ovf_before   = overflow;
    err_v_before = err_valid;
    bus_write(STDIO_BASE + addr_t'(N_TILES * STDIO_STRIDE), NEWLINE_CHAR);  // Past last tile
    bus_write(STDERR_ADDR - addr_t'(STDIO_STRIDE), rand_char());
    bus_write(STDERR_ADDR - addr_t'(1), NEWLINE_CHAR);
    bus_idle(20);
    @(negedge clk);
    check_eq("overflow", 32'(ovf_before), 32'(overflow));
    check_eq("err_valid", 32'(err_v_before), 32'(err_valid));

    test_name = "error_word";
    c = char_t'(take_bits(8));
    bus_write(STDERR_ADDR, c);
    bus_idle(1);
    do @(negedge clk); while (!err_valid);
    check_eq("err_count", 32'(c), 32'(err_count));
    c = char_t'(take_bits(8));
    bus_write(STDERR_ADDR, c);
    bus_idle(1);
    @(negedge clk);  // One cycle after the write
    check_eq("err_count", 32'(c), 32'(err_count));
    bus_idle(10);  // Monitor flags any console beat here

    test_name = "overflow";
    t = tile_idx_t'(1);
    for (int i = 0; i < 20; i++) tile_put(t, rand_char());
    tile_put(t, NEWLINE_CHAR);
    bus_idle(1);
    wait_drained();
    check_eq("overflow", 32'(exp_overflow), 32'(overflow));

    test_name = "end";
    if (pending() == 0 && overflow == exp_overflow) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      stop_on_error("Scoreboard not empty or overflow flags wrong at end of run");
    end
  end

endmodule

// ==== sim/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic arst_n_o
);

  localparam time HALF_PERIOD  = 5ns;  // 10 ns clock
  localparam int  RESET_CYCLES = 10;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Reset held low, released on a rising edge
  initial begin
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    arst_n_o <= 1'b1;
  end

endmodule

// ==== hdl/console_top.sv ====
`timescale 1ns/1ps

module console_top
  import console_pkg::*;
  import line_pkg::*;
(
  input  logic               clk,
  input  logic               arst_n_i,
  input  logic               wr_valid_i,
  input  addr_t              wr_addr_i,
  input  char_t              wr_data_i,
  output logic               char_valid_o,
  output char_t              char_o,
  output tile_idx_t          char_tile_o,
  output logic               err_valid_o,
  output char_t              err_count_o,
  output logic [N_TILES-1:0] overflow_o
);

  char_push_if push_if ();  // Decoder to buffer
  line_pop_if  pop_if ();   // Buffer to drain

  console_decoder u_decoder (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .wr_valid_i  (wr_valid_i),
    .wr_addr_i   (wr_addr_i),
    .wr_data_i   (wr_data_i),
    .push_o      (push_if.source),
    .err_valid_o (err_valid_o),
    .err_count_o (err_count_o)
  );

  line_buffer u_buffer (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .push_i     (push_if.sink),
    .pop_i      (pop_if.store),
    .overflow_o (overflow_o)
  );

  line_drain u_drain (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .pop_o        (pop_if.drain),
    .char_valid_o (char_valid_o),
    .char_o       (char_o),
    .char_tile_o  (char_tile_o)
  );

endmodule

// ==== hdl/line_drain.sv ====
`timescale 1ns/1ps

module line_drain
  import console_pkg::*;
  import line_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n_i,
  line_pop_if.drain pop_o,
  output logic      char_valid_o,
  output char_t     char_o,
  output tile_idx_t char_tile_o
);

  logic      busy_q;       // Mid-line, locked onto one tile
  tile_idx_t lock_tile_q;
  logic      pick_any;     // Some tile has a full line
  tile_idx_t pick_tile;    // Lowest such tile

  // Priority pick, lowest index wins
  always_comb begin
    pick_any  = 1'b0;
    pick_tile = '0;
    for (int t = N_TILES - 1; t >= 0; t--) begin
      if (pop_o.line_ready[t]) begin
        pick_any  = 1'b1;
        pick_tile = tile_idx_t'(t);
      end
    end
  end

  // First pop happens in the same cycle the tile is picked
  assign pop_o.pop      = busy_q || pick_any;
  assign pop_o.pop_tile = busy_q ? lock_tile_q : pick_tile;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q      <= 1'b0;
      lock_tile_q <= '0;
    end else if (pop_o.pop) begin
      busy_q      <= !pop_o.head_last;  // Back to idle after the newline
      lock_tile_q <= pop_o.pop_tile;
    end
  end

  // One beat out per pop, a cycle later
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      char_valid_o <= 1'b0;
    end else begin
      char_valid_o <= pop_o.pop;
    end
  end

  always_ff @(posedge clk) begin
    if (pop_o.pop) begin
      char_o      <= pop_o.head_data;
      char_tile_o <= pop_o.pop_tile;
    end
  end

endmodule

// ==== hdl/line_buffer.sv ====
`timescale 1ns/1ps

module line_buffer
  import console_pkg::*;
  import line_pkg::*;
(
  input  logic               clk,
  input  logic               arst_n_i,
  char_push_if.sink          push_i,
  line_pop_if.store          pop_i,
  output logic [N_TILES-1:0] overflow_o
);

  char_t mem_data [N_TILES][LINE_DEPTH];
  logic  mem_last [N_TILES][LINE_DEPTH];  // Newline flag per entry
  ptr_t  wr_ptr   [N_TILES];
  ptr_t  rd_ptr   [N_TILES];
  fill_t fill     [N_TILES];
  fill_t line_cnt [N_TILES];              // Complete lines held

  // Head of the FIFO the drain is pointing at
  assign pop_i.head_data = mem_data[pop_i.pop_tile][rd_ptr[pop_i.pop_tile]];
  assign pop_i.head_last = mem_last[pop_i.pop_tile][rd_ptr[pop_i.pop_tile]];

  for (genvar t = 0; t < N_TILES; t++) begin : g_tile
    logic push_hit;
    logic push_ok;
    logic push_drop;
    logic pop_hit;
    logic pop_nl;

    assign push_hit = push_i.push && (push_i.tile == tile_idx_t'(t));
    assign pop_hit  = pop_i.pop && (pop_i.pop_tile == tile_idx_t'(t));
    assign pop_nl   = pop_hit && mem_last[t][rd_ptr[t]];

    // Newline only needs one slot, others must leave one spare
    assign push_ok = push_hit && (push_i.is_newline ?
                                  (fill[t] != fill_t'(LINE_DEPTH)) :
                                  (fill[t] < fill_t'(LINE_DEPTH - 1)));
    assign push_drop = push_hit && !push_ok;

    assign pop_i.line_ready[t] = (line_cnt[t] != '0);

    always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
        wr_ptr[t]     <= '0;
        rd_ptr[t]     <= '0;
        fill[t]       <= '0;
        line_cnt[t]   <= '0;
        overflow_o[t] <= 1'b0;
      end else begin
        if (push_ok) begin
          wr_ptr[t] <= (wr_ptr[t] == ptr_t'(LINE_DEPTH - 1)) ? '0 : wr_ptr[t] + 1'b1;
        end
        if (pop_hit) begin
          rd_ptr[t] <= (rd_ptr[t] == ptr_t'(LINE_DEPTH - 1)) ? '0 : rd_ptr[t] + 1'b1;
        end
        // Push and pop may hit the same tile in one cycle
        fill[t]     <= fill[t] + fill_t'(push_ok) - fill_t'(pop_hit);
        line_cnt[t] <= line_cnt[t] + fill_t'(push_ok && push_i.is_newline)
                       - fill_t'(pop_nl);
        if (push_drop) overflow_o[t] <= 1'b1;  // Sticky
      end
    end

    // Storage write
    always_ff @(posedge clk) begin
      if (push_ok) begin
        mem_data[t][wr_ptr[t]] <= push_i.data;
        mem_last[t][wr_ptr[t]] <= push_i.is_newline;
      end
    end
  end

endmodule

// ==== hdl/console_decoder.sv ====
`timescale 1ns/1ps

module console_decoder
  import console_pkg::*;
  import line_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n_i,
  input  logic        wr_valid_i,
  input  addr_t       wr_addr_i,
  input  char_t       wr_data_i,
  char_push_if.source push_o,
  output logic        err_valid_o,
  output char_t       err_count_o
);

  logic      stdio_hit;   // Write lands on some tile's stdio word
  tile_idx_t stdio_tile;  // Which one
  logic      stderr_hit;

  // Match against every stdio address
  always_comb begin
    stdio_hit  = 1'b0;
    stdio_tile = '0;
    for (int t = 0; t < N_TILES; t++) begin
      if (wr_addr_i == STDIO_BASE + addr_t'(t * STDIO_STRIDE)) begin
        stdio_hit  = wr_valid_i;
        stdio_tile = tile_idx_t'(t);
      end
    end
  end

  assign stderr_hit = wr_valid_i && (wr_addr_i == STDERR_ADDR);

  // Push strobe, one cycle after the write
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      push_o.push <= 1'b0;
      err_valid_o <= 1'b0;
    end else begin
      push_o.push <= stdio_hit;
      if (stderr_hit) err_valid_o <= 1'b1;  // Sticky once written
    end
  end

  // Payload only loads on a hit
  always_ff @(posedge clk) begin
    if (stdio_hit) begin
      push_o.tile       <= stdio_tile;
      push_o.data       <= wr_data_i;
      push_o.is_newline <= (wr_data_i == NEWLINE_CHAR);
    end
    if (stderr_hit) begin
      err_count_o <= wr_data_i;  // Exit error count
    end
  end

endmodule

// ==== hdl/console_ifs.sv ====
`timescale 1ns/1ps

// Decoded character going into the per-tile store
interface char_push_if
  import console_pkg::*;
  import line_pkg::*;
();
  logic      push;        // One-cycle strobe
  tile_idx_t tile;        // Target tile
  char_t     data;
  logic      is_newline;  // data == NEWLINE_CHAR

  modport source (output push, tile, data, is_newline);
  modport sink   (input  push, tile, data, is_newline);
endinterface

// Store side exposes ready lines and the head of one FIFO
interface line_pop_if
  import console_pkg::*;
  import line_pkg::*;
();
  logic [N_TILES-1:0] line_ready;  // Per tile, one or more full lines held
  logic               pop;         // Remove head at the edge
  tile_idx_t          pop_tile;    // Also selects head_data
  char_t              head_data;
  logic               head_last;   // Head entry is a newline

  modport store (
    output line_ready, head_data, head_last,
    input  pop, pop_tile
  );

  modport drain (
    input  line_ready, head_data, head_last,
    output pop, pop_tile
  );
endinterface

// ==== hdl/line_pkg.sv ====
package line_pkg;

  // One console character
  typedef logic [7:0] char_t;

  // ASCII line feed ends a line
  localparam char_t NEWLINE_CHAR = 8'd10;

  // Entries per tile FIFO
  localparam int unsigned LINE_DEPTH = 16;

  // Fill count, 0 up to LINE_DEPTH inclusive
  typedef logic [$clog2(LINE_DEPTH+1)-1:0] fill_t;

  // Read and write pointer into one FIFO
  typedef logic [$clog2(LINE_DEPTH)-1:0] ptr_t;

  // A non-newline needs two free slots
  // so the terminating newline always finds room


endpackage

// ==== hdl/console_pkg.sv ====
package console_pkg;

  // Tile count on the mesh
  localparam int unsigned N_TILES = 4;

  // Write address width
  localparam int unsigned ADDR_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;

  // Tile index, two bits for four tiles
  typedef logic [$clog2(N_TILES)-1:0] tile_idx_t;

  // Shared error-count word, low byte only
  localparam addr_t STDERR_ADDR = 32'h5FFF0000;

  // stdio address of tile 0
  localparam addr_t STDIO_BASE = 32'h5FFF0004;

  // Byte step to the next tile's stdio word
  localparam int unsigned STDIO_STRIDE = 4;

  // Last tile sits at STDIO_BASE + (N_TILES-1)*STDIO_STRIDE
  // Anything past that, or between the two regions, is not decoded


endpackage
